/* design/forth_pkg.sv */
//////////////////////////////
// forth processor package
// widths, opcodes, stack commands and the boot program
//////////////////////////////
`default_nettype none

package forth_pkg;

	// data path and program sizes
	localparam int cell_width = 32;
	localparam int pc_width = 6;
	localparam int rom_depth = 64;
	localparam int data_stack_depth = 16;
	localparam int data_stack_ptr_width = $clog2(data_stack_depth);

	// serial timing, kept short for simulation
	localparam int uart_clks_per_bit = 16;
	localparam int uart_cnt_width = $clog2(uart_clks_per_bit);

	// leds on the board are active low
	localparam logic led_on = 1'b0;
	localparam logic led_off = 1'b1;

	// inner interpreter words
	typedef enum logic [7:0] {
		op_lit          = 8'h01,
		op_plus         = 8'h02,
		op_minus        = 8'h03,
		op_dup          = 8'h04,
		op_over         = 8'h05,
		op_drop         = 8'h06,
		op_equal        = 8'h07,
		op_zero_equal   = 8'h08,
		op_and          = 8'h09,
		op_or           = 8'h0a,
		op_branch       = 8'h0b,
		op_zero_branch  = 8'h0c,
		op_emit         = 8'h0d,
		op_led_store    = 8'h0e,
		op_button_fetch = 8'h0f
	} op_e;

	// data stack commands, applied at the clock edge
	typedef enum logic [2:0] {
		stack_hold        = 3'd0,
		stack_push        = 3'd1,
		stack_pop         = 3'd2,
		stack_replace     = 3'd3,
		stack_pop_replace = 3'd4
	} stack_cmd_e;

	//////////////////////////////
	// boot program
	//////////////////////////////
	// inline cells follow lit, branch and zero-branch
	localparam logic [cell_width-1:0] program_rom [rom_depth] = '{
		// countdown from 5, emit ascii digit each pass
		0:  op_lit,
		1:  32'd5,
		2:  op_dup,
		3:  op_lit,
		4:  32'h30,
		5:  op_plus,
		6:  op_emit,
		7:  op_lit,
		8:  32'd1,
		9:  op_minus,
		10: op_dup,
		11: op_zero_equal,
		12: op_zero_branch,
		13: 32'd2,
		// drop counter, fetch buttons, show on leds
		14: op_drop,
		15: op_button_fetch,
		16: op_dup,
		17: op_led_store,
		18: op_lit,
		19: 32'h41,
		20: op_plus,
		21: op_emit,
		// logic byte: (0x2a | (0x6f == 0x2a)) & 0x6f
		22: op_lit,
		23: 32'h6f,
		24: op_lit,
		25: 32'h2a,
		26: op_over,
		27: op_over,
		28: op_equal,
		29: op_or,
		30: op_and,
		31: op_emit,
		// park here
		32: op_branch,
		33: 32'd32,
		default: '0
	};

endpackage

`default_nettype wire

/* design/forth_data_stack.sv */
//////////////////////////////
// circular data stack
// top and second read combinationally
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module forth_data_stack (
	input  logic                            clk,
	input  logic                            reset,
	input  forth_pkg::stack_cmd_e           cmd,
	input  logic [forth_pkg::cell_width-1:0] wdata,
	output logic [forth_pkg::cell_width-1:0] tos,
	output logic [forth_pkg::cell_width-1:0] nos
);

	import forth_pkg::*;

	// stack cells, no reset on payload
	logic [cell_width-1:0] cells [data_stack_depth];

	// pointer to top entry, wraps on over and underflow
	logic [data_stack_ptr_width-1:0] sp;
	logic [data_stack_ptr_width-1:0] sp_up;
	logic [data_stack_ptr_width-1:0] sp_down;

	assign sp_up = sp + 1'b1;
	assign sp_down = sp - 1'b1;

	// top and the one below it
	assign tos = cells[sp];
	assign nos = cells[sp_down];

	// pointer moves
	always_ff @(posedge clk) begin
		if (!reset) begin
			sp <= '0;
		end else begin
			case (cmd)
				stack_push: sp <= sp_up;
				stack_pop, stack_pop_replace: sp <= sp_down;
				default: sp <= sp;
			endcase
		end
	end

	// cell writes
	always_ff @(posedge clk) begin
		case (cmd)
			// new top above the old one
			stack_push: cells[sp_up] <= wdata;
			stack_replace: cells[sp] <= wdata;
			// second becomes the new top
			stack_pop_replace: cells[sp_down] <= wdata;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* design/forth_alu.sv */
//////////////////////////////
// forth alu
// new top of stack per word
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module forth_alu (
	input  forth_pkg::op_e                   op,
	input  logic [forth_pkg::cell_width-1:0] tos,
	input  logic [forth_pkg::cell_width-1:0] nos,
	input  logic [forth_pkg::cell_width-1:0] literal,
	input  logic [1:0]                       buttons,
	output logic [forth_pkg::cell_width-1:0] result
);

	import forth_pkg::*;

	always_comb begin
		case (op)
			// arithmetic, second op top
			op_plus: result = nos + tos;
			op_minus: result = nos - tos;
			// bitwise
			op_and: result = nos & tos;
			op_or: result = nos | tos;
			// forth flags, true is all ones
			op_equal: result = (nos == tos) ? '1 : '0;
			op_zero_equal: result = (tos == '0) ? '1 : '0;
			// copies
			op_over: result = nos;
			op_dup: result = tos;
			// inline cell after lit
			op_lit: result = literal;
			// button1 in bit 1, button0 in bit 0
			op_button_fetch: result = {{(cell_width - 2){1'b0}}, buttons};
			// no write for the others
			default: result = tos;
		endcase
	end

endmodule

`default_nettype wire

/* design/forth_sequencer.sv */
//////////////////////////////
// forth inner interpreter
// fetch, decode, branch, literal, emit and led store
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module forth_sequencer (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [forth_pkg::cell_width-1:0] tos,
	input  logic [forth_pkg::cell_width-1:0] result,
	output forth_pkg::stack_cmd_e            stack_cmd,
	output logic [forth_pkg::cell_width-1:0] stack_wdata,
	output forth_pkg::op_e                   alu_op,
	output logic [forth_pkg::cell_width-1:0] literal,
	output logic                             tx_valid,
	output logic [7:0]                       tx_data,
	input  logic                             tx_ready,
	output logic                             led_r,
	output logic                             led_g,
	output logic                             led_b
);

	import forth_pkg::*;

	// program counter and two-word phase
	logic [pc_width-1:0] pc;
	logic second;
	// word that owns the inline cell
	op_e held_op;

	logic [cell_width-1:0] rom_word;
	op_e fetched_op;
	logic tos_zero;
	logic transfer;

	//////////////////////////////
	// fetch and decode
	//////////////////////////////
	assign rom_word = program_rom[pc];
	assign fetched_op = op_e'(rom_word[7:0]);

	// inline phase keeps the earlier word on the alu
	assign alu_op = second ? held_op : fetched_op;
	assign literal = rom_word;
	assign stack_wdata = result;

	assign tos_zero = (tos == '0);

	// emit waits for the transmitter
	assign tx_valid = !second && (fetched_op == op_emit);
	assign tx_data = tos[7:0];
	assign transfer = tx_valid && tx_ready;

	// stack command per word
	always_comb begin
		stack_cmd = stack_hold;
		if (second) begin
			case (held_op)
				op_lit: stack_cmd = stack_push;
				// flag consumed either way
				op_zero_branch: stack_cmd = stack_pop;
				default: stack_cmd = stack_hold;
			endcase
		end else begin
			case (fetched_op)
				op_plus, op_minus, op_and, op_or, op_equal: stack_cmd = stack_pop_replace;
				op_zero_equal: stack_cmd = stack_replace;
				op_dup, op_over, op_button_fetch: stack_cmd = stack_push;
				op_drop, op_led_store: stack_cmd = stack_pop;
				// pop only when the byte leaves
				op_emit: stack_cmd = transfer ? stack_pop : stack_hold;
				// lit and branches act in the inline phase
				default: stack_cmd = stack_hold;
			endcase
		end
	end

	//////////////////////////////
	// pc, phase and leds
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
			second <= 1'b0;
			held_op <= op_lit;
			led_r <= led_off;
			led_g <= led_off;
			led_b <= led_off;
		end else if (second) begin
			// inline cell at pc
			second <= 1'b0;
			case (held_op)
				op_branch: pc <= rom_word[pc_width-1:0];
				op_zero_branch: begin
					if (tos_zero) begin
						pc <= rom_word[pc_width-1:0];
					end else begin
						pc <= pc + 1'b1;
					end
				end
				default: pc <= pc + 1'b1;
			endcase
		end else begin
			case (fetched_op)
				op_lit, op_branch, op_zero_branch: begin
					second <= 1'b1;
					held_op <= fetched_op;
					pc <= pc + 1'b1;
				end
				op_emit: begin
					// hold pc while tx is busy
					if (transfer) begin
						pc <= pc + 1'b1;
					end
				end
				op_led_store: begin
					// bit 0 green, bit 1 blue, bit 2 red
					led_g <= tos[0] ? led_on : led_off;
					led_b <= tos[1] ? led_on : led_off;
					led_r <= tos[2] ? led_on : led_off;
					pc <= pc + 1'b1;
				end
				// unknown codes step over
				default: pc <= pc + 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/uart_tx.sv */
//////////////////////////////
// serial transmitter, 8N1
// one frame per accepted byte
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_valid,
	input  logic [7:0] tx_data,
	output logic       tx_ready,
	output logic       tx
);

	import forth_pkg::*;

	logic busy;
	// clocks into the current bit
	logic [uart_cnt_width-1:0] clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_idx;
	logic [7:0] shift;
	logic bit_done;

	assign tx_ready = !busy;
	assign bit_done = (clk_cnt == uart_cnt_width'(uart_clks_per_bit - 1));

	// control and line
	always_ff @(posedge clk) begin
		if (!reset) begin
			busy <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx <= 1'b1;
		end else if (!busy) begin
			// start bit goes out the cycle after acceptance
			if (tx_valid) begin
				busy <= 1'b1;
				clk_cnt <= '0;
				bit_idx <= '0;
				tx <= 1'b0;
			end
		end else if (bit_done) begin
			clk_cnt <= '0;
			if (bit_idx == 4'd9) begin
				// stop bit finished, line stays high
				busy <= 1'b0;
			end else begin
				bit_idx <= bit_idx + 1'b1;
				// stop bit after the eighth data bit
				tx <= (bit_idx == 4'd8) ? 1'b1 : shift[0];
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// data shifter, lsb first
	always_ff @(posedge clk) begin
		if (!busy && tx_valid) begin
			shift <= tx_data;
		end else if (busy && bit_done && bit_idx < 4'd8) begin
			shift <= shift >> 1;
		end
	end

endmodule

`default_nettype wire

/* design/forth_proc.sv */
//////////////////////////////
// forth processor top
// sequencer, stack, alu and serial tx
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module forth_proc (
	input  logic clk,
	input  logic reset,
	input  logic button0,
	input  logic button1,
	output logic tx,
	output logic led_r,
	output logic led_g,
	output logic led_b
);

	import forth_pkg::*;

	// stack link
	stack_cmd_e stack_cmd;
	logic [cell_width-1:0] stack_wdata;
	logic [cell_width-1:0] tos;
	logic [cell_width-1:0] nos;

	// alu link
	op_e alu_op;
	logic [cell_width-1:0] literal;
	logic [cell_width-1:0] result;

	// transmitter handshake
	logic tx_valid;
	logic tx_ready;
	logic [7:0] tx_data;

	forth_sequencer u_forth_sequencer (
		.clk         (clk),
		.reset       (reset),
		.tos         (tos),
		.result      (result),
		.stack_cmd   (stack_cmd),
		.stack_wdata (stack_wdata),
		.alu_op      (alu_op),
		.literal     (literal),
		.tx_valid    (tx_valid),
		.tx_data     (tx_data),
		.tx_ready    (tx_ready),
		.led_r       (led_r),
		.led_g       (led_g),
		.led_b       (led_b)
	);

	forth_data_stack u_forth_data_stack (
		.clk   (clk),
		.reset (reset),
		.cmd   (stack_cmd),
		.wdata (stack_wdata),
		.tos   (tos),
		.nos   (nos)
	);

	// buttons straight from the pins
	forth_alu u_forth_alu (
		.op      (alu_op),
		.tos     (tos),
		.nos     (nos),
		.literal (literal),
		.buttons ({button1, button0}),
		.result  (result)
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.reset    (reset),
		.tx_valid (tx_valid),
		.tx_data  (tx_data),
		.tx_ready (tx_ready),
		.tx       (tx)
	);

endmodule

`default_nettype wire

/* tb/forth_ref.svh */
//////////////////////////////
// forth reference model
// runs the boot program for one button setting
//////////////////////////////
`ifndef forth_ref_svh
`define forth_ref_svh

typedef logic [7:0] byte_q_t [$];

// model stack, circular like the hardware one
logic [cell_width-1:0] model_stack [data_stack_depth];
int model_sp;

function automatic void push_cell(input logic [cell_width-1:0] value);
	model_sp = (model_sp + 1) % data_stack_depth;
	model_stack[model_sp] = value;
endfunction

function automatic logic [cell_width-1:0] pop_cell();
	logic [cell_width-1:0] value;
	value = model_stack[model_sp];
	model_sp = (model_sp + data_stack_depth - 1) % data_stack_depth;
	return value;
endfunction

// expected frames and final {r, g, b} pins for one button pair
function automatic void interpret_program(input logic [1:0] buttons, output byte_q_t bytes,
		output logic [2:0] leds);
	int pc;
	int next;
	int steps;
	int target;
	logic parked;
	logic [cell_width-1:0] a;
	logic [cell_width-1:0] b;
	logic [cell_width-1:0] inline_cell;
	bytes = {};
	leds = {3{led_off}};
	model_sp = 0;
	pc = 0;
	steps = 0;
	parked = 1'b0;
	while (!parked && steps < 1000) begin
		inline_cell = program_rom[(pc + 1) % rom_depth];
		target = int'(inline_cell[pc_width-1:0]);
		next = pc + 1;
		steps++;
		case (op_e'(program_rom[pc][7:0]))
			op_lit: begin
				push_cell(inline_cell);
				next = pc + 2;
			end
			op_plus: begin
				b = pop_cell();
				a = pop_cell();
				push_cell(a + b);
			end
			op_minus: begin
				b = pop_cell();
				a = pop_cell();
				push_cell(a - b);
			end
			op_and: begin
				b = pop_cell();
				a = pop_cell();
				push_cell(a & b);
			end
			op_or: begin
				b = pop_cell();
				a = pop_cell();
				push_cell(a | b);
			end
			op_equal: begin
				b = pop_cell();
				a = pop_cell();
				push_cell((a == b) ? {cell_width{1'b1}} : '0);
			end
			op_zero_equal: begin
				a = pop_cell();
				push_cell((a == '0) ? {cell_width{1'b1}} : '0);
			end
			op_dup: begin
				a = pop_cell();
				push_cell(a);
				push_cell(a);
			end
			op_over: begin
				b = pop_cell();
				a = pop_cell();
				push_cell(a);
				push_cell(b);
				push_cell(a);
			end
			op_drop: void'(pop_cell());
			// a branch onto itself is the park loop
			op_branch: begin
				parked = (target == pc);
				next = target;
			end
			op_zero_branch: next = (pop_cell() == '0) ? target : pc + 2;
			op_emit: begin
				a = pop_cell();
				bytes.push_back(a[7:0]);
			end
			// bit 2 red, bit 0 green, bit 1 blue
			op_led_store: begin
				a = pop_cell();
				leds = {a[2] ? led_on : led_off, a[0] ? led_on : led_off, a[1] ? led_on : led_off};
			end
			op_button_fetch: push_cell({{(cell_width - 2){1'b0}}, buttons});
			default: ;
		endcase
		pc = next % rom_depth;
	end
endfunction

`endif

/* tb/forth_checker.sv */
//////////////////////////////
// forth processor checker
// decodes tx frames, compares bytes and leds to the model
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module forth_checker (
	input  logic       clk,
	input  logic       reset,
	input  logic [1:0] buttons,
	input  logic       tx,
	input  logic       led_r,
	input  logic       led_g,
	input  logic       led_b,
	output logic       run_done,
	output int         error_count,
	output int         byte_count
);

	import forth_pkg::*;
	`include "forth_ref.svh"

	byte_q_t expected;
	logic [2:0] expected_leds;
	logic [7:0] data;
	logic seen_start;
	int cycles;
	int window;
	int received;

	// all sampling on the falling edge
	task automatic wait_cycle();
		@(negedge clk);
		cycles++;
	endtask

	// line idle, leds dark
	task automatic check_idle();
		if (tx !== 1'b1) begin
			$display("error tx: got %h expected 1", tx);
			error_count++;
		end
		if ({led_r, led_g, led_b} !== {3{led_off}}) begin
			$display("error {led_r, led_g, led_b}: got %h expected %h",
				{led_r, led_g, led_b}, {3{led_off}});
			error_count++;
		end
	endtask

	// entered half a clock into the start bit
	task automatic receive_frame(output logic [7:0] value);
		int i;
		repeat (uart_clks_per_bit / 2 - 1) wait_cycle();
		if (tx !== 1'b0) begin
			$display("error tx start bit: got %h expected 0", tx);
			error_count++;
		end
		// mid-bit samples, lsb first
		for (i = 0; i < 8; i++) begin
			repeat (uart_clks_per_bit) wait_cycle();
			value[i] = tx;
		end
		repeat (uart_clks_per_bit) wait_cycle();
		if (tx !== 1'b1) begin
			$display("error tx stop bit: got %h expected 1", tx);
			error_count++;
		end
	endtask

	initial begin
		run_done = 1'b0;
		error_count = 0;
		byte_count = 0;
		forever begin
			// a new run starts with reset
			@(negedge clk);
			while (reset !== 1'b0) @(negedge clk);
			run_done = 1'b0;
			interpret_program(buttons, expected, expected_leds);
			window = expected.size() * 10 * uart_clks_per_bit * 2 + 200;
			// first reset edge still shows the old leds
			@(negedge clk);
			while (reset === 1'b0) begin
				check_idle();
				@(negedge clk);
			end
			received = 0;
			cycles = 0;
			seen_start = 1'b0;
			while (cycles < window) begin
				if (tx === 1'b0) begin
					seen_start = 1'b1;
					receive_frame(data);
					if (received >= expected.size()) begin
						$display("frame %0d (0x%02h) arrived after the program should have parked",
							received, data);
						error_count++;
					end else if (data !== expected[received]) begin
						$display("error tx byte %0d: got 0x%02h expected 0x%02h",
							received, data, expected[received]);
						error_count++;
					end
					received++;
					byte_count++;
				end else if (!seen_start) begin
					check_idle();
				end
				wait_cycle();
			end
			// leds settle well before the window closes
			if ({led_r, led_g, led_b} !== expected_leds) begin
				$display("error {led_r, led_g, led_b}: got %h expected %h",
					{led_r, led_g, led_b}, expected_leds);
				error_count++;
			end
			if (received < expected.size()) begin
				$display("run with buttons %0d timed out after %0d cycles, %0d of %0d bytes received",
					buttons, cycles, received, expected.size());
				error_count++;
			end
			run_done = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* tb/tb_forth_proc.sv */
//////////////////////////////
// forth processor testbench
// four runs, one per button setting
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_forth_proc;

	import forth_pkg::*;

	logic clk = 1'b0;
	logic reset;
	logic button0;
	logic button1;
	logic tx;
	logic led_r;
	logic led_g;
	logic led_b;
	logic run_done;
	int error_count;
	int byte_count;
	// button pairs in run order
	logic [1:0] order [4];
	logic [1:0] swap;
	int i;
	int j;

	// 8 ns period
	always #4 clk = ~clk;

	forth_proc u_forth_proc (
		.clk     (clk),
		.reset   (reset),
		.button0 (button0),
		.button1 (button1),
		.tx      (tx),
		.led_r   (led_r),
		.led_g   (led_g),
		.led_b   (led_b)
	);

	forth_checker u_forth_checker (
		.clk         (clk),
		.reset       (reset),
		.buttons     ({button1, button0}),
		.tx          (tx),
		.led_r       (led_r),
		.led_g       (led_g),
		.led_b       (led_b),
		.run_done    (run_done),
		.error_count (error_count),
		.byte_count  (byte_count)
	);

	initial begin
		reset = 1'b0;
		button0 = 1'b0;
		button1 = 1'b0;
		void'($urandom(8277));
		for (i = 0; i < 4; i++) begin
			order[i] = 2'(i);
		end
		// shuffle the four settings
		for (i = 3; i > 0; i--) begin
			j = int'($urandom_range(i, 0));
			swap = order[i];
			order[i] = order[j];
			order[j] = swap;
		end
		for (i = 0; i < 4; i++) begin
			@(posedge clk);
			reset <= 1'b0;
			button0 <= order[i][0];
			button1 <= order[i][1];
			repeat (10) @(posedge clk);
			reset <= 1'b1;
			// checker closes the run when its window ends
			@(posedge clk);
			while (!run_done) @(posedge clk);
		end
		$display("runs 4, bytes %0d, errors %0d", byte_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* forth_proc.f */
+incdir+tb
design/forth_pkg.sv
design/forth_data_stack.sv
design/forth_alu.sv
design/forth_sequencer.sv
design/uart_tx.sv
design/forth_proc.sv
tb/forth_checker.sv
tb/tb_forth_proc.sv

/* run.sh */
#!/bin/sh
# build and run the forth processor testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_forth_proc -f forth_proc.f \
	-Mdir obj_dir -o sim_forth_proc > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_forth_proc > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0
